// ==== include/clock_settings.svh ====
`ifndef CLOCK_SETTINGS_SVH
`define CLOCK_SETTINGS_SVH

// clock cycles per one-second tick, 8 keeps simulation short.
`define CLK_PER_SEC 8

// clock cycles per blink phase.
`define BLINK_HALF 2

`endif

// ==== logic/clock_pkg.sv ====
package clock_pkg;

	typedef logic [3:0] bcd_t; // one display digit.
	typedef logic [23:0] disp_word_t; // hour tens in 23:20.

	// one-hot main modes.
	typedef enum logic [2:0]
	{
		clock_set = 3'b001,
		clock24 = 3'b010,
		alarm = 3'b100
	} main_mode_t;

	// fld_idle doubles as the on/off screen in alarm mode.
	typedef enum logic [6:0]
	{
		fld_idle = 7'b0000001,
		fld_hour_t = 7'b0000010,
		fld_hour_o = 7'b0000100,
		fld_min_t = 7'b0001000,
		fld_min_o = 7'b0010000,
		fld_sec_t = 7'b0100000,
		fld_sec_o = 7'b1000000
	} set_field_t;

	// step a digit, back to 0 past its last value.
	function automatic bcd_t bcd_inc(input bcd_t d, input bcd_t last);
		return (d >= last) ? 4'd0 : d + 4'd1;
	endfunction

	// the hour ones stops at 3 in the twenties.
	function automatic bcd_t hour_o_last(input bcd_t ht);
		return (ht == 4'd2) ? 4'd3 : 4'd9;
	endfunction

endpackage

// ==== logic/clock_digits_if.sv ====
`timescale 1ns/1ps

interface clock_digits_if import clock_pkg::*; ();

	bcd_t hour_t;
	bcd_t hour_o;
	bcd_t min_t;
	bcd_t min_o;
	bcd_t sec_t;
	bcd_t sec_o;

	modport src (output hour_t, hour_o, min_t, min_o, sec_t, sec_o);

	modport snk (input hour_t, hour_o, min_t, min_o, sec_t, sec_o);

endinterface

// ==== logic/time_counter.sv ====
`timescale 1ns/1ps
`include "clock_settings.svh"

module time_counter import clock_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input main_mode_t mode,
	input set_field_t field,
	input logic edit_up,
	clock_digits_if.src time_d
);

	localparam int PW = $clog2(`CLK_PER_SEC + 1);
	localparam logic [PW-1:0] PRE_LAST = PW'(`CLK_PER_SEC - 1);

	logic [PW-1:0] pre_cnt;
	logic running;
	logic tick;
	bcd_t hour_t, hour_o, min_t, min_o, sec_t, sec_o;
	bcd_t hour_t_nxt;

	assign running = (mode != clock_set) || (field == fld_idle);
	assign tick = running && (pre_cnt == PRE_LAST);
	assign hour_t_nxt = bcd_inc(hour_t, 4'd2);

	// ########################################
	// seconds prescaler
	// ########################################
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pre_cnt <= '0;
		else if (tick)
			pre_cnt <= '0;
		else if (running)
			pre_cnt <= pre_cnt + 1'b1;
	end

	// ########################################
	// time of day and digit editing
	// ########################################
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hour_t <= '0;
			hour_o <= '0;
			min_t <= '0;
			min_o <= '0;
			sec_t <= '0;
			sec_o <= '0;
		end
		else if (tick)
		begin
			sec_o <= bcd_inc(sec_o, 4'd9);
			if (sec_o == 4'd9)
			begin
				sec_t <= bcd_inc(sec_t, 4'd5);
				if (sec_t == 4'd5)
				begin
					min_o <= bcd_inc(min_o, 4'd9);
					if (min_o == 4'd9)
					begin
						min_t <= bcd_inc(min_t, 4'd5);
						if (min_t == 4'd5)
						begin
							hour_o <= bcd_inc(hour_o, hour_o_last(hour_t));
							if (hour_o == hour_o_last(hour_t))
								hour_t <= hour_t_nxt; // 23 wraps to 00 here.
						end
					end
				end
			end
		end
		else if (edit_up && mode == clock_set)
		begin
			case (field)
				fld_hour_t:
				begin
					hour_t <= hour_t_nxt;
					if (hour_t_nxt == 4'd2 && hour_o > 4'd3)
						hour_o <= '0; // no 24..29.
				end
				fld_hour_o: hour_o <= bcd_inc(hour_o, hour_o_last(hour_t));
				fld_min_t: min_t <= bcd_inc(min_t, 4'd5);
				fld_min_o: min_o <= bcd_inc(min_o, 4'd9);
				fld_sec_t: sec_t <= bcd_inc(sec_t, 4'd5);
				fld_sec_o: sec_o <= bcd_inc(sec_o, 4'd9);
				default: ;
			endcase
		end
	end

	assign time_d.hour_t = hour_t;
	assign time_d.hour_o = hour_o;
	assign time_d.min_t = min_t;
	assign time_d.min_o = min_o;
	assign time_d.sec_t = sec_t;
	assign time_d.sec_o = sec_o;

endmodule

// ==== logic/alarm_store.sv ====
`timescale 1ns/1ps

module alarm_store import clock_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input main_mode_t mode,
	input set_field_t field,
	input logic edit_up,
	clock_digits_if.snk time_d,
	clock_digits_if.src alarm_d,
	output logic alarm_on,
	output logic alarm_ring
);

	bcd_t al_hour_t, al_hour_o, al_min_t, al_min_o;
	bcd_t al_hour_t_nxt;
	logic al_edit;
	logic on_nxt;
	logic match;

	assign al_edit = edit_up && (mode == alarm);
	assign al_hour_t_nxt = bcd_inc(al_hour_t, 4'd2);
	assign on_nxt = alarm_on ^ (al_edit && field == fld_idle);

	// hours and minutes only, so the ring lasts the whole minute.
	assign match = (time_d.hour_t == al_hour_t) && (time_d.hour_o == al_hour_o) &&
		(time_d.min_t == al_min_t) && (time_d.min_o == al_min_o);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			al_hour_t <= '0;
			al_hour_o <= '0;
			al_min_t <= '0;
			al_min_o <= '0;
			alarm_on <= 1'b0;
			alarm_ring <= 1'b0;
		end
		else
		begin
			alarm_on <= on_nxt;
			alarm_ring <= on_nxt && match; // drops with the switch, not a cycle late.
			if (al_edit)
			begin
				case (field)
					fld_hour_t:
					begin
						al_hour_t <= al_hour_t_nxt;
						if (al_hour_t_nxt == 4'd2 && al_hour_o > 4'd3)
							al_hour_o <= '0;
					end
					fld_hour_o: al_hour_o <= bcd_inc(al_hour_o, hour_o_last(al_hour_t));
					fld_min_t: al_min_t <= bcd_inc(al_min_t, 4'd5);
					fld_min_o: al_min_o <= bcd_inc(al_min_o, 4'd9);
					default: ;
				endcase
			end
		end
	end

	assign alarm_d.hour_t = al_hour_t;
	assign alarm_d.hour_o = al_hour_o;
	assign alarm_d.min_t = al_min_t;
	assign alarm_d.min_o = al_min_o;
	assign alarm_d.sec_t = 4'd0;
	assign alarm_d.sec_o = 4'd0;

endmodule

// ==== logic/mode_ctrl.sv ====
`timescale 1ns/1ps
`include "clock_settings.svh"

module mode_ctrl import clock_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic btn_mode,
	input logic btn_next,
	input logic btn_up,
	output main_mode_t mode,
	output set_field_t field,
	output logic blink,
	output logic edit_up
);

	localparam int BW = $clog2(`BLINK_HALF + 1);
	localparam logic [BW-1:0] BLINK_LAST = BW'(`BLINK_HALF - 1);

	logic [BW-1:0] blink_cnt;

	// ########################################
	// main mode and edit field
	// ########################################
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mode <= clock24;
			field <= fld_idle;
		end
		else if (btn_mode)
		begin
			case (mode)
				clock24: mode <= clock_set;
				clock_set: mode <= alarm;
				default: mode <= clock24;
			endcase
			field <= fld_idle;
		end
		else if (btn_next && mode != clock24)
		begin
			case (field)
				fld_idle: field <= fld_hour_t;
				fld_hour_t: field <= fld_hour_o;
				fld_hour_o: field <= fld_min_t;
				fld_min_t: field <= fld_min_o;
				fld_min_o: field <= (mode == alarm) ? fld_idle : fld_sec_t; // no alarm seconds.
				fld_sec_t: field <= fld_sec_o;
				default: field <= fld_idle;
			endcase
		end
	end

	// ########################################
	// blink phase and edit pulse
	// ########################################
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			blink_cnt <= '0;
			blink <= 1'b0;
			edit_up <= 1'b0;
		end
		else
		begin
			edit_up <= btn_up;
			blink_cnt <= (blink_cnt == BLINK_LAST) ? '0 : blink_cnt + 1'b1;
			if (mode == clock24)
				blink <= 1'b0;
			else if (blink_cnt == BLINK_LAST)
				blink <= ~blink;
		end
	end

endmodule

// ==== logic/display_select.sv ====
`timescale 1ns/1ps

module display_select import clock_pkg::*;
(
	input main_mode_t mode,
	input set_field_t field,
	input logic blink,
	input logic alarm_on,
	clock_digits_if.snk time_d,
	clock_digits_if.snk alarm_d,
	output disp_word_t disp
);

	disp_word_t time_w;
	disp_word_t alarm_w;
	disp_word_t blink_mask;
	logic [5:0] sel; // bit 5 is the hour tens.

	assign time_w = {time_d.hour_t, time_d.hour_o, time_d.min_t,
		time_d.min_o, time_d.sec_t, time_d.sec_o};
	assign alarm_w = {alarm_d.hour_t, alarm_d.hour_o, alarm_d.min_t,
		alarm_d.min_o, alarm_d.sec_t, alarm_d.sec_o};

	// digits under edit.
	always_comb
	begin
		case (field)
			fld_hour_t: sel = 6'b100000;
			fld_hour_o: sel = 6'b010000;
			fld_min_t: sel = 6'b001000;
			fld_min_o: sel = 6'b000100;
			fld_sec_t: sel = 6'b000010;
			fld_sec_o: sel = 6'b000001;
			default: sel = 6'b111111; // idle blinks the whole time.
		endcase
	end

	// a blinking digit is forced to the blank code.
	always_comb
	begin
		for (int i = 0; i < 6; i++)
			blink_mask[i*4 +: 4] = {4{sel[i] & blink}};
	end

	always_comb
	begin
		case (mode)
			clock24:
			begin
				disp = time_w;
				if (time_d.hour_t == 4'd0)
					disp[23:20] = 4'hf; // no leading zero.
			end
			alarm:
			begin
				if (field == fld_idle)
					disp = alarm_on ? 24'hffffed : 24'hfffecc;
				else
					disp = alarm_w | blink_mask;
			end
			default: disp = time_w | blink_mask;
		endcase
	end

endmodule

// ==== logic/alarm_clock_top.sv ====
`timescale 1ns/1ps

module alarm_clock_top import clock_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic btn_mode,
	input logic btn_next,
	input logic btn_up,
	output logic [23:0] disp_out,
	output logic alarm_ring
);

	main_mode_t mode;
	set_field_t field;
	logic blink;
	logic edit_up;
	logic alarm_on;

	clock_digits_if time_if ();
	clock_digits_if alarm_if ();

	mode_ctrl mode_ctrl_i (
		.clk (clk),
		.rst_n (rst_n),
		.btn_mode (btn_mode),
		.btn_next (btn_next),
		.btn_up (btn_up),
		.mode (mode),
		.field (field),
		.blink (blink),
		.edit_up (edit_up)
	);

	time_counter time_counter_i (
		.clk (clk),
		.rst_n (rst_n),
		.mode (mode),
		.field (field),
		.edit_up (edit_up),
		.time_d (time_if.src)
	);

	alarm_store alarm_store_i (
		.clk (clk),
		.rst_n (rst_n),
		.mode (mode),
		.field (field),
		.edit_up (edit_up),
		.time_d (time_if.snk),
		.alarm_d (alarm_if.src),
		.alarm_on (alarm_on),
		.alarm_ring (alarm_ring)
	);

	display_select display_select_i (
		.mode (mode),
		.field (field),
		.blink (blink),
		.alarm_on (alarm_on),
		.time_d (time_if.snk),
		.alarm_d (alarm_if.snk),
		.disp (disp_out)
	);

endmodule

// ==== test/alarm_clock_chk.sv ====
`timescale 1ns/1ps

module alarm_clock_chk import clock_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input set_field_t field,
	input logic alarm_on,
	input logic alarm_ring,
	clock_digits_if.snk time_d,
	clock_digits_if.snk alarm_d
);

	int err_cnt = 0; // read by the testbench at the end.

	// each digit in its own BCD range, and at most 23 hours.
	function automatic logic digits_valid(input bcd_t ht, ho, mt, mo, st, so);
		return ht <= 4'd2 && ho <= 4'd9 && mt <= 4'd5 && mo <= 4'd9 &&
			st <= 4'd5 && so <= 4'd9 && {ht, ho} <= 8'h23;
	endfunction

	time_range_a: assert property (@(posedge clk) disable iff (!rst_n)
		digits_valid(time_d.hour_t, time_d.hour_o, time_d.min_t,
			time_d.min_o, time_d.sec_t, time_d.sec_o))
	else
	begin
		err_cnt++;
		$error("time digits out of range");
	end

	alarm_range_a: assert property (@(posedge clk) disable iff (!rst_n)
		digits_valid(alarm_d.hour_t, alarm_d.hour_o, alarm_d.min_t,
			alarm_d.min_o, alarm_d.sec_t, alarm_d.sec_o))
	else
	begin
		err_cnt++;
		$error("alarm digits out of range");
	end

	field_onehot_a: assert property (@(posedge clk) disable iff (!rst_n) $onehot(field))
	else
	begin
		err_cnt++;
		$error("edit field is not one-hot");
	end

	// ring only while the alarm is switched on.
	ring_on_a: assert property (@(posedge clk) disable iff (!rst_n) alarm_ring |-> alarm_on)
	else
	begin
		err_cnt++;
		$error("alarm_ring high with the alarm off");
	end

endmodule

bind alarm_clock_top alarm_clock_chk chk_i (
	.clk (clk),
	.rst_n (rst_n),
	.field (field),
	.alarm_on (alarm_on),
	.alarm_ring (alarm_ring),
	.time_d (time_if),
	.alarm_d (alarm_if)
);

// ==== test/alarm_clock_tb.sv ====
`timescale 1ns/1ps
`include "clock_settings.svh"

module alarm_clock_tb;

	localparam int CPS = `CLK_PER_SEC;
	localparam int WATCH_NS = 2000 * CPS * 40 + 20000; // 2000 s of ticks plus margin.

	logic clk = 1'b0;
	logic rst_n;
	logic btn_mode;
	logic btn_next;
	logic btn_up;
	logic [23:0] disp_out;
	logic alarm_ring;
	logic checking = 1'b0;

	// model state with mode 0 as clock24, 1 as clock_set, 2 as alarm and field 0 as idle.
	int m_mode;
	int m_field;
	int bcnt;
	int pre_m;
	int tod; // seconds since midnight.
	logic edit_m;
	logic blink_m;
	logic a_on;
	logic ring_m;
	logic [23:0] al_w;

	alarm_clock_top dut_i (
		.clk (clk),
		.rst_n (rst_n),
		.btn_mode (btn_mode),
		.btn_next (btn_next),
		.btn_up (btn_up),
		.disp_out (disp_out),
		.alarm_ring (alarm_ring)
	);

	always #20 clk = ~clk;

	function automatic logic [23:0] to_word(input int s);
		int h;
		int m;
		int sec;
		h = s / 3600;
		m = (s / 60) % 60;
		sec = s % 60;
		return {4'(h / 10), 4'(h % 10), 4'(m / 10), 4'(m % 10), 4'(sec / 10), 4'(sec % 10)};
	endfunction

	function automatic int to_tod(input logic [23:0] w);
		return (int'(w[23:20]) * 10 + int'(w[19:16])) * 3600 +
			(int'(w[15:12]) * 10 + int'(w[11:8])) * 60 + int'(w[7:4]) * 10 + int'(w[3:0]);
	endfunction

	// one up press on digit idx, 0 being the hour tens, no carry.
	function automatic logic [23:0] bump(input logic [23:0] w, input int idx);
		int d;
		int top;
		d = int'(w[23 - 4*idx -: 4]);
		case (idx)
			0: top = 2;
			1: top = (w[23:20] == 4'd2) ? 3 : 9;
			2, 4: top = 5;
			default: top = 9;
		endcase
		d = (d >= top) ? 0 : d + 1;
		w[23 - 4*idx -: 4] = 4'(d);
		if (idx == 0 && d == 2 && w[19:16] > 4'd3)
			w[19:16] = 4'd0;
		return w;
	endfunction

	function automatic logic [23:0] expect_disp();
		logic [23:0] w;
		if (m_mode == 0)
		begin
			w = to_word(tod);
			if (w[23:20] == 4'd0)
				w[23:20] = 4'hf;
		end
		else if (m_mode == 2 && m_field == 0)
			w = a_on ? 24'hffffed : 24'hfffecc;
		else
		begin
			w = (m_mode == 1) ? to_word(tod) : al_w;
			if (blink_m && m_field == 0)
				w = 24'hffffff;
			else if (blink_m)
				w[27 - 4*m_field -: 4] = 4'hf;
		end
		return w;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// ########################################
	// reference model and value checks
	// ########################################
	always @(posedge clk)
	begin
		logic [23:0] tw;
		logic on_nxt;
		tw = to_word(tod);
		on_nxt = a_on ^ (edit_m && m_mode == 2 && m_field == 0);
		if (!rst_n)
		begin
			m_mode <= 0;
			m_field <= 0;
			bcnt <= 0;
			pre_m <= 0;
			tod <= 0;
			edit_m <= 1'b0;
			blink_m <= 1'b0;
			a_on <= 1'b0;
			ring_m <= 1'b0;
			al_w <= '0;
		end
		else
		begin
			if (btn_mode)
			begin
				m_mode <= (m_mode + 1) % 3;
				m_field <= 0;
			end
			else if (btn_next && m_mode != 0)
				m_field <= (m_mode == 2 && m_field == 4) ? 0 : (m_field + 1) % 7;
			edit_m <= btn_up;
			bcnt <= (bcnt + 1) % `BLINK_HALF;
			if (m_mode == 0)
				blink_m <= 1'b0;
			else if (bcnt == `BLINK_HALF - 1)
				blink_m <= ~blink_m;
			if (m_mode != 1 || m_field == 0)
			begin
				if (pre_m == CPS - 1)
				begin
					pre_m <= 0;
					tod <= (tod + 1) % 86400;
				end
				else
					pre_m <= pre_m + 1;
			end
			else if (edit_m)
				tod <= to_tod(bump(tw, m_field - 1)); // clock_set with a field selected.
			if (edit_m && m_mode == 2 && m_field >= 1 && m_field <= 4)
				al_w <= bump(al_w, m_field - 1);
			a_on <= on_nxt;
			ring_m <= on_nxt && (al_w[23:8] == tw[23:8]);
		end
	end

	always @(negedge clk)
	begin
		assert (dut_i.chk_i.err_cnt == 0) else
			stop_run("an assertion in the bound checker failed");
		if (checking)
		begin
			assert (disp_out === expect_disp()) else
				stop_run($sformatf("Mismatch at %0t: disp_out %h, expected %h",
					$time, disp_out, expect_disp()));
			assert (alarm_ring === ring_m) else
				stop_run($sformatf("Mismatch at %0t: alarm_ring %b, expected %b",
					$time, alarm_ring, ring_m));
		end
	end

	// ########################################
	// stimulus
	// ########################################
	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// 0 is the mode button, 1 next, 2 up.
	task automatic pulse(input int which);
		@(posedge clk);
		#2;
		btn_mode = (which == 0);
		btn_next = (which == 1);
		btn_up = (which == 2);
		@(posedge clk);
		#2;
		btn_mode = 1'b0;
		btn_next = 1'b0;
		btn_up = 1'b0;
	endtask

	task automatic goto_mode(input int m);
		while (m_mode != m)
			pulse(0);
	endtask

	task automatic goto_field(input int f);
		while (m_field != f)
			pulse(1);
	endtask

	task automatic set_digit(input int idx, input logic [3:0] target);
		logic [23:0] w;
		goto_field(idx + 1);
		w = to_word(tod);
		while (w[23 - 4*idx -: 4] != target)
		begin
			pulse(2);
			idle(1);
			w = to_word(tod);
		end
	endtask

	// hour tens first, so the hour ones can reach its range.
	task automatic set_time(input logic [23:0] target);
		for (int i = 0; i < 6; i++)
			set_digit(i, target[23 - 4*i -: 4]);
	endtask

	task automatic set_alarm(input logic [23:0] target);
		for (int i = 0; i < 4; i++)
		begin
			goto_field(i + 1);
			while (al_w[23 - 4*i -: 4] != target[23 - 4*i -: 4])
			begin
				pulse(2);
				idle(1);
			end
		end
	endtask

	task automatic wait_ring(input logic level, input int max_cycles);
		int n;
		n = 0;
		while (alarm_ring !== level && n < max_cycles)
		begin
			@(negedge clk);
			n++;
		end
		assert (alarm_ring === level) else
			stop_run($sformatf("alarm_ring did not go to %b within %0d cycles", level, max_cycles));
	endtask

	initial
	begin
		void'($urandom(92));
		rst_n = 1'b0;
		btn_mode = 1'b0;
		btn_next = 1'b0;
		btn_up = 1'b0;
		repeat (8) @(posedge clk);
		#2 rst_n = 1'b1;
		@(negedge clk);
		assert (disp_out === 24'hf00000 && alarm_ring === 1'b0) else
			stop_run($sformatf("Mismatch at %0t: after reset disp_out %h, alarm_ring %b",
				$time, disp_out, alarm_ring));
		checking = 1'b1;
		idle(130 * CPS); // two minute carries.
		goto_mode(1);
		repeat (60)
		begin
			if ($urandom % 3 == 0)
				pulse(1);
			else
				pulse(2);
			idle($urandom % 4);
		end
		set_time(24'h195940);
		goto_mode(0);
		idle(30 * CPS); // into the twenties.
		goto_mode(1);
		set_time(24'h235940);
		goto_mode(0);
		idle(30 * CPS); // through midnight.
		goto_mode(2);
		pulse(2);
		idle(3);
		pulse(2);
		idle(3);
		set_alarm(to_word((tod + 120) % 86400));
		goto_field(0);
		pulse(2);
		idle(1);
		goto_mode(0);
		wait_ring(1'b1, 200 * CPS);
		wait_ring(1'b0, 70 * CPS);
		goto_mode(2);
		pulse(2); // switch off.
		idle(1);
		set_alarm(to_word((tod + 60) % 86400));
		goto_mode(0);
		idle(90 * CPS);
		if (dut_i.chk_i.err_cnt == 0)
			$display("=== PASS ===");
		else
		begin
			$display("bound checker assertions failed");
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial
	begin
		#(WATCH_NS);
		stop_run("watchdog timeout, the test phases did not finish in time");
	end

endmodule

// ==== flist.f ====
+incdir+include
logic/clock_pkg.sv
logic/clock_digits_if.sv
logic/time_counter.sv
logic/alarm_store.sv
logic/mode_ctrl.sv
logic/display_select.sv
logic/alarm_clock_top.sv
test/alarm_clock_chk.sv
test/alarm_clock_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run with Verilator, a failed build or run also marks the log as failed.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module alarm_clock_tb -f flist.f -o sim_tb > sim.log 2>&1 &&
	./obj_dir/sim_tb >> sim.log 2>&1 ||
	echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
